// File: source/wb_pkg.sv
`default_nettype none

package wb_pkg;

    // slot geometry of one retiring instruction
    localparam int NUM_SLOTS = 4;
    localparam int SLOT_W    = 64;   // result slot payload
    localparam int ADDR_W    = 32;   // memory address / destination field
    localparam int IE_TYPE_W = 4;
    localparam int REG_IDX_W = 3;    // eight architectural registers per bank

    // operand size, also used for store size
    typedef enum logic [1:0] {
        SZ_BYTE  = 2'd0,
        SZ_WORD  = 2'd1,
        SZ_DWORD = 2'd2,
        SZ_QWORD = 2'd3
    } wb_size_e;

    // micro-op class as seen by writeback
    typedef enum logic [2:0] {
        POP_NONE     = 3'd0,   // ordinary op
        POP_JMP_FAR  = 3'd1,   // loads EIP and CS
        POP_CALL_FAR = 3'd2,
        POP_IRET     = 3'd3,
        POP_HLT      = 3'd4
    } wb_pop_e;

endpackage

`default_nettype wire

// File: source/wb_if.sv
`timescale 1ns/1ps
`default_nettype none

// register file write bundle, one per bank
interface wb_reg_if import wb_pkg::*; ();
    logic [NUM_SLOTS-1:0]                ld;    // per-slot write enable
    logic [NUM_SLOTS-1:0][REG_IDX_W-1:0] idx;
    logic [NUM_SLOTS-1:0][SLOT_W-1:0]    data;
    wb_size_e                            size;  // shared by all slots

    modport src (output ld, idx, data, size);
    modport dst (input ld, idx, data, size);
endinterface

// store request into the write-address queue
interface wb_mem_if import wb_pkg::*; ();
    logic              push;
    logic [ADDR_W-1:0] addr;
    logic [SLOT_W-1:0] data;
    wb_size_e          size;
    logic              full;   // back from the queue

    modport src (output push, addr, data, size, input full);
    modport dst (input push, addr, data, size, output full);
endinterface

`default_nettype wire

// File: source/writeback_unit.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_unit import wb_pkg::*; (
    input  logic                             valid_in,
    input  wb_pop_e                          pop,
    input  logic [3:0]                       mem_size_ovr,
    input  logic [NUM_SLOTS-1:0][SLOT_W-1:0] slot_data,
    input  logic [NUM_SLOTS-1:0][ADDR_W-1:0] slot_dest,
    input  logic [NUM_SLOTS-1:0]             slot_is_reg,
    input  logic [NUM_SLOTS-1:0]             slot_is_seg,
    input  logic [NUM_SLOTS-1:0]             slot_is_mem,
    input  logic [NUM_SLOTS-1:0]             slot_wb,
    input  wb_size_e                         slot_size,
    input  logic [ADDR_W-1:0]                eip,
    input  logic [ADDR_W-1:0]                br_fip,
    input  logic [ADDR_W-1:0]                br_fip_p1,
    input  logic                             br_taken,
    input  logic                             br_correct,
    input  logic                             ie,
    input  logic [IE_TYPE_W-1:0]             ie_type,
    input  logic                             interrupt,
    wb_reg_if.src                            gpr,
    wb_reg_if.src                            seg,
    wb_mem_if.src                            mem,
    output logic                             valid_out,
    output logic                             stall,
    output logic                             resteer,
    output logic [ADDR_W-1:0]                new_eip,
    output logic [ADDR_W-1:0]                new_fip_e,
    output logic [ADDR_W-1:0]                new_fip_o,
    output logic                             halt,
    output logic                             ie_val,
    output logic [IE_TYPE_W-1:0]             ie_type_out
);

    localparam int SEL_W = $clog2(NUM_SLOTS);

    logic                             far_op;
    logic [NUM_SLOTS-1:0]             mem_cand;   // store slots before the stall check
    logic                             has_store;
    logic [SEL_W-1:0]                 st_sel;
    wb_size_e                         ovr_size;
    logic [NUM_SLOTS-1:0][SLOT_W-1:0] res_data;
    logic [ADDR_W-1:0]                line_a;
    logic [ADDR_W-1:0]                line_b;

    assign far_op = (pop inside {POP_JMP_FAR, POP_CALL_FAR, POP_IRET});

    // qualify with valid_in, not valid_out, or stall would loop on itself
    assign mem_cand  = slot_is_mem & slot_wb & {NUM_SLOTS{valid_in}};
    assign has_store = |mem_cand;
    assign stall     = has_store & mem.full;
    assign valid_out = valid_in & ~stall;

    // selector substitution for far transfers
    always_comb begin
        res_data = slot_data;
        if (far_op)
            res_data[0] = {{(SLOT_W-16){1'b0}}, slot_data[0][47:32]};
    end

    assign gpr.ld   = slot_is_reg & slot_wb & {NUM_SLOTS{valid_out}};
    assign seg.ld   = slot_is_seg & slot_wb & {NUM_SLOTS{valid_out}};
    assign gpr.data = res_data;
    assign seg.data = res_data;
    assign gpr.size = slot_size;
    assign seg.size = slot_size;

    always_comb begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            gpr.idx[s] = slot_dest[s][REG_IDX_W-1:0];
            seg.idx[s] = slot_dest[s][REG_IDX_W-1:0];
        end
    end

    // lowest memory slot wins, scan from the top down
    always_comb begin
        st_sel = '0;
        for (int s = NUM_SLOTS - 1; s >= 0; s--)
            if (mem_cand[s])
                st_sel = SEL_W'(s);
    end

    always_comb begin
        ovr_size = slot_size;
        for (int k = 3; k >= 0; k--)
            if (mem_size_ovr[k])
                ovr_size = wb_size_e'(2'(k));
    end

    assign mem.push = has_store & valid_out;
    assign mem.addr = slot_dest[st_sel];
    assign mem.data = slot_data[st_sel];   // raw payload, far call stores CS:EIP
    assign mem.size = far_op ? SZ_QWORD : ovr_size;

    // branch target and fetch lines
    assign new_eip = !br_taken ? eip
                   : far_op    ? slot_data[0][ADDR_W-1:0]
                   :             br_fip;

    assign line_a    = {br_fip[ADDR_W-1:4], 4'b0000};
    assign line_b    = {br_fip_p1[ADDR_W-1:4], 4'b0000};
    assign new_fip_e = br_fip[4] ? line_b : line_a;
    assign new_fip_o = br_fip[4] ? line_a : line_b;

    assign resteer = valid_out & ~br_correct;
    assign halt    = valid_in & (pop == POP_HLT);

    assign ie_val      = ie | interrupt;
    assign ie_type_out = {interrupt, ie_type[IE_TYPE_W-2:0]};

    // a writing slot targets one place only
    always_comb begin
        for (int s = 0; s < NUM_SLOTS; s++)
            if (valid_in && slot_wb[s])
                assert ($onehot0({slot_is_reg[s], slot_is_seg[s], slot_is_mem[s]}))
                    else $error("slot %0d has more than one target kind", s);
    end

endmodule

`default_nettype wire

// File: source/reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module reg_bank import wb_pkg::*; #(
    parameter int REG_W = 32
) (
    input  logic                 clk,
    input  logic                 rst_n,
    wb_reg_if.dst                wr,
    input  logic [REG_IDX_W-1:0] rd_idx,
    output logic [REG_W-1:0]     rd_data
);

    localparam int NUM_REGS = 2 ** REG_IDX_W;

    logic [REG_W-1:0] regs     [NUM_REGS];
    logic [REG_W-1:0] regs_nxt [NUM_REGS];

    // slots applied in order, so a later slot overrides an earlier one
    always_comb begin
        regs_nxt = regs;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (wr.ld[s]) begin
                case (wr.size)
                    SZ_BYTE: regs_nxt[wr.idx[s]][7:0]  = wr.data[s][7:0];   // AL style
                    SZ_WORD: regs_nxt[wr.idx[s]][15:0] = wr.data[s][15:0];
                    default: regs_nxt[wr.idx[s]]       = wr.data[s][REG_W-1:0];
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_REGS; r++)
                regs[r] <= '0;
        end else begin
            regs <= regs_nxt;
        end
    end

    assign rd_data = regs[rd_idx];   // no bypass, visible next cycle

endmodule

`default_nettype wire

// File: source/wb_store_queue.sv
`timescale 1ns/1ps
`default_nettype none

module wb_store_queue import wb_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    wb_mem_if.dst             enq,
    output logic              st_valid,
    input  logic              st_ready,
    output logic [ADDR_W-1:0] st_addr,
    output logic [SLOT_W-1:0] st_data,
    output wb_size_e          st_size
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic [ADDR_W-1:0] q_addr [QUEUE_DEPTH];
    logic [SLOT_W-1:0] q_data [QUEUE_DEPTH];
    wb_size_e          q_size [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = enq.push;
    assign do_pop  = st_valid & st_ready;

    assign enq.full = (count == CNT_W'(QUEUE_DEPTH));
    assign st_valid = (count != '0);

    always_ff @(posedge clk) begin
        if (do_push) begin
            q_addr[wr_ptr] <= enq.addr;
            q_data[wr_ptr] <= enq.data;
            q_size[wr_ptr] <= enq.size;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

    // head shown while not empty
    assign st_addr = q_addr[rd_ptr];
    assign st_data = q_data[rd_ptr];
    assign st_size = q_size[rd_ptr];

    // the unit must hold its store back with stall
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        enq.push |-> !enq.full);

    // a waiting head stays put until taken
    a_head_stable: assert property (@(posedge clk) disable iff (!rst_n)
        st_valid && !st_ready |=> st_valid && $stable(st_addr) && $stable(st_data));

endmodule

`default_nettype wire

// File: source/wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module wb_top import wb_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             valid_in,
    input  wb_pop_e                          pop,
    input  logic [3:0]                       mem_size_ovr,
    input  logic [NUM_SLOTS-1:0][SLOT_W-1:0] slot_data,
    input  logic [NUM_SLOTS-1:0][ADDR_W-1:0] slot_dest,
    input  logic [NUM_SLOTS-1:0]             slot_is_reg,
    input  logic [NUM_SLOTS-1:0]             slot_is_seg,
    input  logic [NUM_SLOTS-1:0]             slot_is_mem,
    input  logic [NUM_SLOTS-1:0]             slot_wb,
    input  wb_size_e                         slot_size,
    input  logic [ADDR_W-1:0]                eip,
    input  logic [ADDR_W-1:0]                br_fip,
    input  logic [ADDR_W-1:0]                br_fip_p1,
    input  logic                             br_taken,
    input  logic                             br_correct,
    input  logic                             ie,
    input  logic [IE_TYPE_W-1:0]             ie_type,
    input  logic                             interrupt,
    output logic                             valid_out,
    output logic                             stall,
    output logic                             resteer,
    output logic [ADDR_W-1:0]                new_eip,
    output logic [ADDR_W-1:0]                new_fip_e,
    output logic [ADDR_W-1:0]                new_fip_o,
    output logic                             halt,
    output logic                             ie_val,
    output logic [IE_TYPE_W-1:0]             ie_type_out,
    input  logic [REG_IDX_W-1:0]             gpr_rd_idx,
    output logic [31:0]                      gpr_rd_data,
    input  logic [REG_IDX_W-1:0]             seg_rd_idx,
    output logic [15:0]                      seg_rd_data,
    output logic                             st_valid,
    input  logic                             st_ready,
    output logic [ADDR_W-1:0]                st_addr,
    output logic [SLOT_W-1:0]                st_data,
    output wb_size_e                         st_size
);

    wb_reg_if gpr_if ();
    wb_reg_if seg_if ();
    wb_mem_if mem_if ();

    writeback_unit u_wb (
        .valid_in    (valid_in),
        .pop         (pop),
        .mem_size_ovr(mem_size_ovr),
        .slot_data   (slot_data),
        .slot_dest   (slot_dest),
        .slot_is_reg (slot_is_reg),
        .slot_is_seg (slot_is_seg),
        .slot_is_mem (slot_is_mem),
        .slot_wb     (slot_wb),
        .slot_size   (slot_size),
        .eip         (eip),
        .br_fip      (br_fip),
        .br_fip_p1   (br_fip_p1),
        .br_taken    (br_taken),
        .br_correct  (br_correct),
        .ie          (ie),
        .ie_type     (ie_type),
        .interrupt   (interrupt),
        .gpr         (gpr_if.src),
        .seg         (seg_if.src),
        .mem         (mem_if.src),
        .valid_out   (valid_out),
        .stall       (stall),
        .resteer     (resteer),
        .new_eip     (new_eip),
        .new_fip_e   (new_fip_e),
        .new_fip_o   (new_fip_o),
        .halt        (halt),
        .ie_val      (ie_val),
        .ie_type_out (ie_type_out)
    );

    // general registers
    reg_bank #(.REG_W(32)) u_gpr (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr     (gpr_if.dst),
        .rd_idx (gpr_rd_idx),
        .rd_data(gpr_rd_data)
    );

    // segment selectors
    reg_bank #(.REG_W(16)) u_seg (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr     (seg_if.dst),
        .rd_idx (seg_rd_idx),
        .rd_data(seg_rd_data)
    );

    wb_store_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_wbaq (
        .clk     (clk),
        .rst_n   (rst_n),
        .enq     (mem_if.dst),
        .st_valid(st_valid),
        .st_ready(st_ready),
        .st_addr (st_addr),
        .st_data (st_data),
        .st_size (st_size)
    );

endmodule

`default_nettype wire

// File: tests/wb_tb.sv
`timescale 1ns/1ps
`default_nettype none

module wb_tb import wb_pkg::*; ();

    logic                             clk;
    logic                             rst_n;
    logic                             valid_in;
    wb_pop_e                          pop;
    logic [3:0]                       mem_size_ovr;
    logic [NUM_SLOTS-1:0][SLOT_W-1:0] slot_data;
    logic [NUM_SLOTS-1:0][ADDR_W-1:0] slot_dest;
    logic [NUM_SLOTS-1:0]             slot_is_reg;
    logic [NUM_SLOTS-1:0]             slot_is_seg;
    logic [NUM_SLOTS-1:0]             slot_is_mem;
    logic [NUM_SLOTS-1:0]             slot_wb;
    wb_size_e                         slot_size;
    logic [ADDR_W-1:0]                eip;
    logic [ADDR_W-1:0]                br_fip;
    logic [ADDR_W-1:0]                br_fip_p1;
    logic                             br_taken;
    logic                             br_correct;
    logic                             ie;
    logic [IE_TYPE_W-1:0]             ie_type;
    logic                             interrupt;
    logic                             valid_out;
    logic                             stall;
    logic                             resteer;
    logic [ADDR_W-1:0]                new_eip;
    logic [ADDR_W-1:0]                new_fip_e;
    logic [ADDR_W-1:0]                new_fip_o;
    logic                             halt;
    logic                             ie_val;
    logic [IE_TYPE_W-1:0]             ie_type_out;
    logic [REG_IDX_W-1:0]             gpr_rd_idx;
    logic [31:0]                      gpr_rd_data;
    logic [REG_IDX_W-1:0]             seg_rd_idx;
    logic [15:0]                      seg_rd_data;
    logic                             st_valid;
    logic                             st_ready;
    logic [ADDR_W-1:0]                st_addr;
    logic [SLOT_W-1:0]                st_data;
    wb_size_e                         st_size;

    string       steps[$];         // stimulus lines without comments
    logic [63:0] fields [42];      // 27 inputs then 15 expected values
    int          limit     = 0;
    int          cycle_cnt = 0;
    int          errors    = 0;

    wb_top #(.QUEUE_DEPTH(4)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic load_steps();
        int    fd;
        string line;
        fd = $fopen("tests/wb_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file tests/wb_stim.txt");
            $display("tests failed");
            $fatal(1, "no stimulus");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#")   // skip blank and comment lines
                    steps.push_back(line);
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_step(input string line);
        int n;
        n = $sscanf(line,
            "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
            fields[0], fields[1], fields[2], fields[3], fields[4], fields[5], fields[6],
            fields[7], fields[8], fields[9], fields[10], fields[11], fields[12], fields[13],
            fields[14], fields[15], fields[16], fields[17], fields[18], fields[19], fields[20],
            fields[21], fields[22], fields[23], fields[24], fields[25], fields[26], fields[27],
            fields[28], fields[29], fields[30], fields[31], fields[32], fields[33], fields[34],
            fields[35], fields[36], fields[37], fields[38], fields[39], fields[40], fields[41]);
        if (n != 42) begin
            $display("stimulus line has %0d fields instead of 42: %s", n, line);
            $display("tests failed");
            $fatal(1, "bad stimulus line");
        end else begin
            valid_in     = fields[0][0];
            pop          = wb_pop_e'(fields[1][2:0]);
            mem_size_ovr = fields[2][3:0];
            slot_is_reg  = fields[3][3:0];
            slot_is_seg  = fields[4][3:0];
            slot_is_mem  = fields[5][3:0];
            slot_wb      = fields[6][3:0];
            slot_size    = wb_size_e'(fields[7][1:0]);
            for (int s = 0; s < NUM_SLOTS; s++) begin
                slot_data[s] = fields[8+s];
                slot_dest[s] = fields[12+s][31:0];
            end
            eip        = fields[16][31:0];
            br_fip     = fields[17][31:0];
            br_fip_p1  = fields[18][31:0];
            br_taken   = fields[19][0];
            br_correct = fields[20][0];
            ie         = fields[21][0];
            ie_type    = fields[22][3:0];
            interrupt  = fields[23][0];
            st_ready   = fields[24][0];
            gpr_rd_idx = fields[25][2:0];
            seg_rd_idx = fields[26][2:0];
            #3;   // just ahead of the rising edge
            compare_value("valid_out", 64'(valid_out), fields[27]);
            compare_value("stall", 64'(stall), fields[28]);
            compare_value("resteer", 64'(resteer), fields[29]);
            compare_value("new_eip", 64'(new_eip), fields[30]);
            compare_value("new_fip_e", 64'(new_fip_e), fields[31]);
            compare_value("new_fip_o", 64'(new_fip_o), fields[32]);
            compare_value("halt", 64'(halt), fields[33]);
            compare_value("ie_val", 64'(ie_val), fields[34]);
            compare_value("ie_type_out", 64'(ie_type_out), fields[35]);
            compare_value("gpr_rd_data", 64'(gpr_rd_data), fields[36]);
            compare_value("seg_rd_data", 64'(seg_rd_data), fields[37]);
            compare_value("st_valid", 64'(st_valid), fields[38]);
            if (fields[38][0]) begin   // head only meaningful when not empty
                compare_value("st_addr", 64'(st_addr), fields[39]);
                compare_value("st_data", st_data, fields[40]);
                compare_value("st_size", 64'(st_size), fields[41]);
            end
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        valid_in     = 1'b0;
        pop          = POP_NONE;
        mem_size_ovr = '0;
        slot_data    = '0;
        slot_dest    = '0;
        slot_is_reg  = '0;
        slot_is_seg  = '0;
        slot_is_mem  = '0;
        slot_wb      = '0;
        slot_size    = SZ_DWORD;
        eip          = '0;
        br_fip       = '0;
        br_fip_p1    = '0;
        br_taken     = 1'b0;
        br_correct   = 1'b1;
        ie           = 1'b0;
        ie_type      = '0;
        interrupt    = 1'b0;
        st_ready     = 1'b0;
        gpr_rd_idx   = '0;
        seg_rd_idx   = '0;
        load_steps();
        limit = 4 * steps.size() + 20;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (steps[i]) begin
            @(negedge clk);
            apply_step(steps[i]);
        end
        if (errors == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("tests failed");
            $fatal(1, "%0d checks failed", errors);
        end
    end

    // watchdog
    initial begin
        wait (limit > 0);
        while (cycle_cnt < limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("tests failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// File: tests/wb_stim.txt
# in: valid pop ovr is_reg is_seg is_mem wb size d0 d1 d2 d3 a0 a1 a2 a3 eip fip fip_p1 taken correct ie ie_type intr st_ready gpr_idx seg_idx
# exp: valid_out stall resteer new_eip fip_e fip_o halt ie_val ie_type gpr seg st_valid st_addr st_data st_size (all hex)
1 0 0 1 0 0 1 2 11223344 0 0 0 1 0 0 0 100 0 0 0 1 0 0 0 0 1 0 1 0 0 100 0 0 0 0 0 0 0 0 0 0 0
1 0 0 1 0 0 1 0 aa 0 0 0 1 0 0 0 100 0 0 0 1 0 0 0 0 1 0 1 0 0 100 0 0 0 0 0 11223344 0 0 0 0 0
1 0 0 1 0 0 1 1 beef 0 0 0 1 0 0 0 100 0 0 0 1 0 0 0 0 1 0 1 0 0 100 0 0 0 0 0 112233aa 0 0 0 0 0
1 0 0 7 0 0 3 2 aaaa0000 55556666 77777777 0 2 2 3 0 100 0 0 0 1 0 0 0 0 1 0 1 0 0 100 0 0 0 0 0 1122beef 0 0 0 0 0
0 0 0 0 0 0 0 2 0 0 0 0 0 0 0 0 100 0 0 0 1 0 0 0 0 2 0 0 0 0 100 0 0 0 0 0 55556666 0 0 0 0 0
1 0 0 0 2 0 2 1 0 1234 0 0 0 5 0 0 100 0 0 0 1 0 0 0 0 3 5 1 0 0 100 0 0 0 0 0 0 0 0 0 0 0
1 1 0 0 1 0 1 2 0000abcd00401000 0 0 0 1 0 0 0 100 0 0 1 1 0 0 0 0 0 5 1 0 0 00401000 0 0 0 0 0 0 1234 0 0 0 0
0 0 0 0 0 0 0 2 0 0 0 0 0 0 0 0 100 0 0 0 1 0 0 0 0 0 1 0 0 0 100 0 0 0 0 0 0 abcd 0 0 0 0
1 0 0 0 0 6 6 2 0 1111 2222 0 0 2000 3000 0 100 0 0 0 1 0 0 0 0 0 0 1 0 0 100 0 0 0 0 0 0 0 0 0 0 0
1 0 6 0 0 1 1 2 3333 0 0 0 2010 0 0 0 100 0 0 0 1 0 0 0 0 0 0 1 0 0 100 0 0 0 0 0 0 0 1 2000 1111 2
1 2 0 0 0 8 8 2 0 0 0 0000123400005678 0 0 0 2020 100 0 0 0 1 0 0 0 0 0 0 1 0 0 100 0 0 0 0 0 0 0 1 2000 1111 2
1 0 1 0 0 1 1 2 44 0 0 0 2030 0 0 0 100 0 0 0 1 0 0 0 0 0 0 1 0 0 100 0 0 0 0 0 0 0 1 2000 1111 2
1 0 0 2 0 1 3 2 55 99999999 0 0 2040 4 0 0 100 0 0 0 1 0 0 0 1 4 0 0 1 0 100 0 0 0 0 0 0 0 1 2000 1111 2
1 0 0 2 0 1 3 2 55 99999999 0 0 2040 4 0 0 100 0 0 0 1 0 0 0 0 4 0 1 0 0 100 0 0 0 0 0 0 0 1 2010 3333 1
0 0 0 0 0 0 0 2 0 0 0 0 0 0 0 0 100 0 0 0 1 0 0 0 1 4 0 0 0 0 100 0 0 0 0 0 99999999 0 1 2010 3333 1
0 0 0 0 0 0 0 2 0 0 0 0 0 0 0 0 100 0 0 0 1 0 0 0 1 4 0 0 0 0 100 0 0 0 0 0 99999999 0 1 2020 0000123400005678 3
0 0 0 0 0 0 0 2 0 0 0 0 0 0 0 0 100 0 0 0 1 0 0 0 0 4 0 0 0 0 100 0 0 0 0 0 99999999 0 1 2030 44 0
0 0 0 0 0 0 0 2 0 0 0 0 0 0 0 0 100 0 0 0 1 0 0 0 1 4 0 0 0 0 100 0 0 0 0 0 99999999 0 1 2030 44 0
0 0 0 0 0 0 0 2 0 0 0 0 0 0 0 0 100 0 0 0 1 0 0 0 1 4 0 0 0 0 100 0 0 0 0 0 99999999 0 1 2040 55 2
0 0 0 0 0 0 0 2 0 0 0 0 0 0 0 0 100 0 0 0 1 0 0 0 0 4 0 0 0 0 100 0 0 0 0 0 99999999 0 0 0 0 0
1 0 0 0 0 0 0 2 0 0 0 0 0 0 0 0 100 12345678 12345688 1 0 0 0 0 0 0 0 1 0 1 12345678 12345680 12345670 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 2 0 0 0 0 0 0 0 0 100 abcf abdf 0 0 0 0 0 0 0 0 0 0 0 100 abc0 abd0 0 0 0 0 0 0 0 0 0
1 4 0 0 0 0 0 2 0 0 0 0 0 0 0 0 100 0 0 0 1 1 5 1 0 0 0 1 0 0 100 0 0 1 1 d 0 0 0 0 0 0
0 4 0 0 0 0 0 2 0 0 0 0 0 0 0 0 100 0 0 0 1 0 a 1 0 0 0 0 0 0 100 0 0 0 1 a 0 0 0 0 0 0

// File: src.f
source/wb_pkg.sv
source/wb_if.sv
source/writeback_unit.sv
source/reg_bank.sv
source/wb_store_queue.sv
source/wb_top.sv
tests/wb_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the writeback testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module wb_tb -o wb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/wb_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
    echo "simulation failed"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi

echo "simulation passed"
exit 0
